//--- debugPkg.sv
// Shared types and SPR map of the debug unit; at most eight breakpoints are addressable
// Host data words are viewed raw or as breakpoint control fields through sprWordU
package debugPkg;

  typedef logic [31:0] wordT;
  typedef logic [15:0] sprIndexT;
  typedef logic [13:0] reasonT;                   // One bit per exception cause

  localparam sprIndexT DvrBase  = 16'h3000;       // Breakpoint values 0x3000..0x3007
  localparam sprIndexT DcrBase  = 16'h3008;       // Breakpoint controls 0x3008..0x300F
  localparam sprIndexT DsrIndex = 16'h3014;
  localparam sprIndexT DrrIndex = 16'h3015;

  localparam int MaxBreakpoints = 8;

  typedef enum logic [2:0] {
    LoadNone     = 3'd0,
    LoadByteZero = 3'd1,
    LoadHalfZero = 3'd2,
    LoadWordZero = 3'd3,
    LoadByteSign = 3'd5,
    LoadHalfSign = 3'd6,
    LoadWordSign = 3'd7
  } loadKindE;

  typedef enum logic [2:0] {
    StoreNone = 3'd0,
    StoreByte = 3'd1,
    StoreHalf = 3'd2,
    StoreWord = 3'd3
  } storeKindE;

  typedef enum logic [2:0] {
    SrcDisabled  = 3'd0,
    SrcFetchAddr = 3'd1,
    SrcLoadAddr  = 3'd2,
    SrcStoreAddr = 3'd3,
    SrcAnyAddr   = 3'd4,                          // Load or store address
    SrcLoadData  = 3'd5,
    SrcStoreData = 3'd6,
    SrcReserved  = 3'd7
  } dcrSourceE;

  typedef enum logic [2:0] {
    CondNever     = 3'd0,
    CondEqual     = 3'd1,
    CondBelow     = 3'd2,                         // Value below breakpoint
    CondAtOrBelow = 3'd3,
    CondAbove     = 3'd4,
    CondAtOrAbove = 3'd5,
    CondNotEqual  = 3'd6,
    CondReserved  = 3'd7
  } dcrCondE;

  typedef struct packed {
    logic [23:0] unusedHigh;
    dcrSourceE   source;                          // Bits 7:5
    logic        isSigned;                        // Bit 4
    dcrCondE     cond;                            // Bits 3:1
    logic        unusedLow;
  } dcrFieldsT;

  typedef union packed {
    wordT      raw;
    dcrFieldsT dcr;
  } sprWordU;

  typedef struct packed {
    logic      valid;
    wordT      fetchAddr;
    wordT      memAddr;
    loadKindE  loadKind;
    storeKindE storeKind;
    wordT      loadData;
    wordT      storeData;
    logic      exceptionTaken;
    reasonT    exceptionReason;
  } coreEventT;

  typedef struct packed {
    logic     strobe;
    sprIndexT index;
    sprWordU  data;
  } sprWriteT;

  typedef struct packed {
    coreEventT  coreEvent;
    logic [3:0] loadStoreStatus;
  } stage1T;

  typedef struct packed {
    logic   valid;
    logic   anyHit;
    logic   exceptionTaken;
    reasonT exceptionReason;
  } stage2T;

endpackage

//--- sprAccessPort.sv
// Four-phase host port; the host must hold address, data and we stable while req is high
// Exactly one access per request, no matter how long req stays high
`timescale 1ns/10ps

module sprAccessPort
(
  input  logic               clock,
  input  logic               rst_i,
  input  logic               hostReq_i,
  input  logic               hostWe_i,
  input  debugPkg::sprIndexT hostAddr_i,
  input  debugPkg::wordT     hostWData_i,
  input  debugPkg::wordT     bpRead_i,
  input  debugPkg::wordT     stopRead_i,
  output logic               hostAck_o,
  output debugPkg::wordT     hostRData_o,
  output debugPkg::sprWriteT sprWrite_o,
  output debugPkg::sprIndexT readAddr_o
);

  typedef enum logic {
    PortIdle,
    PortAck
  } portStateE;

  portStateE state;
  logic      accept;

  assign accept     = (state == PortIdle) && hostReq_i;  // New request seen this cycle
  assign hostAck_o  = (state == PortAck);
  assign readAddr_o = hostAddr_i;                        // Owners decode the index themselves

  always_comb
  begin
    sprWrite_o.strobe   = accept && hostWe_i;            // Lands on the ack-rise edge
    sprWrite_o.index    = hostAddr_i;
    sprWrite_o.data.raw = hostWData_i;
  end

  always_ff @(posedge clock)
  begin
    if (rst_i)
    begin
      state       <= PortIdle;
      hostRData_o <= '0;
    end
    else
    begin
      case (state)
        PortIdle :
          if (hostReq_i)
            state <= PortAck;
        PortAck :
          if (!hostReq_i)
            state <= PortIdle;                           // Ack drops one cycle after req
        default :
          state <= PortIdle;
      endcase
      if (accept && !hostWe_i)
        hostRData_o <= bpRead_i | stopRead_i;            // Non-owners return zero
    end
  end

endmodule

//--- eventCapture.sv
// Stage 1; registers one core event per cycle, no back-pressure
// Status is zero for invalid events and for a simultaneous load and store
`timescale 1ns/10ps

module eventCapture
(
  input  logic                clock,
  input  logic                rst_i,
  input  debugPkg::coreEventT coreEvent_i,
  output debugPkg::stage1T    stage1_o,
  output logic [3:0]          loadStoreStatus_o
);

  debugPkg::stage1T stage1Reg;
  logic [3:0]       statusNext;

  always_comb
  begin
    statusNext = 4'h0;
    if (coreEvent_i.valid && coreEvent_i.loadKind == debugPkg::LoadNone)
      case (coreEvent_i.storeKind)
        debugPkg::StoreByte : statusNext = 4'hA;
        debugPkg::StoreHalf : statusNext = 4'hC;
        debugPkg::StoreWord : statusNext = 4'hE;
        default             : statusNext = 4'h0;  // No access at all
      endcase
    else if (coreEvent_i.valid && coreEvent_i.storeKind == debugPkg::StoreNone)
      case (coreEvent_i.loadKind)
        debugPkg::LoadByteZero : statusNext = 4'h2;
        debugPkg::LoadByteSign : statusNext = 4'h3;
        debugPkg::LoadHalfZero : statusNext = 4'h4;
        debugPkg::LoadHalfSign : statusNext = 4'h5;
        debugPkg::LoadWordZero : statusNext = 4'h6;
        debugPkg::LoadWordSign : statusNext = 4'h7;
        default                : statusNext = 4'h0;
      endcase
  end

  always_ff @(posedge clock)
  begin
    if (rst_i)
    begin
      stage1Reg.coreEvent.valid          <= 1'b0;
      stage1Reg.coreEvent.exceptionTaken <= 1'b0;
      stage1Reg.loadStoreStatus          <= 4'h0;
    end
    else
      stage1Reg <= '{coreEvent: coreEvent_i, loadStoreStatus: statusNext};
  end

  assign stage1_o          = stage1Reg;
  assign loadStoreStatus_o = stage1Reg.loadStoreStatus;

endmodule

//--- breakpointMatch.sv
// Stage 2; breakpoints at or above nrOfBreakpoints ignore writes and read as zero
// DCR keeps bits 7:1 only; "below" means the observed value is below the DVR
`timescale 1ns/10ps

module breakpointMatch #(parameter int nrOfBreakpoints = 4)  // 0 to 8
(
  input  logic               clock,
  input  logic               rst_i,
  input  debugPkg::stage1T   stage1_i,
  input  debugPkg::sprWriteT sprWrite_i,
  input  debugPkg::sprIndexT readAddr_i,
  output debugPkg::stage2T   stage2_o,
  output debugPkg::wordT     readData_o
);

  localparam debugPkg::wordT DcrWriteMask = 32'h0000_00FE;

  debugPkg::wordT                  dvrWord [debugPkg::MaxBreakpoints];
  debugPkg::sprWordU               dcrWord [debugPkg::MaxBreakpoints];
  logic [debugPkg::MaxBreakpoints-1:0] hitVec;
  debugPkg::stage2T                stage2Reg;

  function automatic logic bpHit(input debugPkg::stage1T s, input debugPkg::wordT bpValue,
                                 input debugPkg::sprWordU ctrl);
    debugPkg::wordT value;
    logic           isLoad;
    logic           isStore;
    logic           qualified;
    logic           hit;
    isLoad  = s.coreEvent.loadKind != debugPkg::LoadNone;
    isStore = s.coreEvent.storeKind != debugPkg::StoreNone;
    case (ctrl.dcr.source)
      debugPkg::SrcFetchAddr : value = s.coreEvent.fetchAddr;
      debugPkg::SrcLoadData  : value = s.coreEvent.loadData;
      debugPkg::SrcStoreData : value = s.coreEvent.storeData;
      default                : value = s.coreEvent.memAddr;  // Address sources
    endcase
    case (ctrl.dcr.source)
      debugPkg::SrcFetchAddr : qualified = 1'b1;
      debugPkg::SrcLoadAddr  : qualified = isLoad;
      debugPkg::SrcStoreAddr : qualified = isStore;
      debugPkg::SrcAnyAddr   : qualified = isLoad || isStore;
      debugPkg::SrcLoadData  : qualified = isLoad;
      debugPkg::SrcStoreData : qualified = isStore;
      debugPkg::SrcDisabled,
      debugPkg::SrcReserved  : qualified = 1'b0;
      default                : qualified = 1'b0;
    endcase
    case (ctrl.dcr.cond)
      debugPkg::CondEqual     : hit = value == bpValue;
      debugPkg::CondNotEqual  : hit = value != bpValue;
      debugPkg::CondBelow     : hit = ctrl.dcr.isSigned ? $signed(value) < $signed(bpValue)
                                                        : value < bpValue;
      debugPkg::CondAtOrBelow : hit = ctrl.dcr.isSigned ? $signed(value) <= $signed(bpValue)
                                                        : value <= bpValue;
      debugPkg::CondAbove     : hit = ctrl.dcr.isSigned ? $signed(value) > $signed(bpValue)
                                                        : value > bpValue;
      debugPkg::CondAtOrAbove : hit = ctrl.dcr.isSigned ? $signed(value) >= $signed(bpValue)
                                                        : value >= bpValue;
      debugPkg::CondNever,
      debugPkg::CondReserved  : hit = 1'b0;
      default                 : hit = 1'b0;
    endcase
    return s.coreEvent.valid && qualified && hit;
  endfunction

  for (genvar n = 0; n < debugPkg::MaxBreakpoints; n++)
  begin : gBreakpoint
    if (n < nrOfBreakpoints)
    begin : gImpl
      debugPkg::wordT    dvrReg;
      debugPkg::sprWordU dcrReg;
      logic              dvrWe;
      logic              dcrWe;

      assign dvrWe = sprWrite_i.strobe && sprWrite_i.index[2:0] == 3'(n) &&
                     (sprWrite_i.index >> 3) == (debugPkg::DvrBase >> 3);
      assign dcrWe = sprWrite_i.strobe && sprWrite_i.index[2:0] == 3'(n) &&
                     (sprWrite_i.index >> 3) == (debugPkg::DcrBase >> 3);

      always_ff @(posedge clock)
      begin
        if (rst_i)
        begin
          dvrReg     <= '0;
          dcrReg.raw <= '0;                                    // Never hits after reset
        end
        else
        begin
          if (dvrWe)
            dvrReg <= sprWrite_i.data.raw;
          if (dcrWe)
            dcrReg.raw <= sprWrite_i.data.raw & DcrWriteMask;
        end
      end

      assign dvrWord[n] = dvrReg;
      assign dcrWord[n] = dcrReg;
      assign hitVec[n]  = bpHit(stage1_i, dvrReg, dcrReg);
    end
    else
    begin : gAbsent
      assign dvrWord[n]     = '0;
      assign dcrWord[n].raw = '0;
      assign hitVec[n]      = 1'b0;
    end
  end

  always_comb
  begin
    if ((readAddr_i >> 3) == (debugPkg::DvrBase >> 3))
      readData_o = dvrWord[readAddr_i[2:0]];
    else if ((readAddr_i >> 3) == (debugPkg::DcrBase >> 3))
      readData_o = dcrWord[readAddr_i[2:0]].raw;
    else
      readData_o = '0;                                         // Not one of ours
  end

  always_ff @(posedge clock)
  begin
    if (rst_i)
    begin
      stage2Reg.valid          <= 1'b0;
      stage2Reg.anyHit         <= 1'b0;
      stage2Reg.exceptionTaken <= 1'b0;
    end
    else
    begin
      stage2Reg.valid           <= stage1_i.coreEvent.valid;
      stage2Reg.anyHit          <= |hitVec;
      stage2Reg.exceptionTaken  <= stage1_i.coreEvent.valid && stage1_i.coreEvent.exceptionTaken;
      stage2Reg.exceptionReason <= stage1_i.coreEvent.exceptionReason;
    end
  end

  assign stage2_o = stage2Reg;

endmodule

//--- stopControl.sv
// Stage 3; stall stays set until the host writes DRR
// The exception wins over a host DRR write in the same cycle
`timescale 1ns/10ps

module stopControl
(
  input  logic               clock,
  input  logic               rst_i,
  input  debugPkg::stage2T   stage2_i,
  input  debugPkg::sprWriteT sprWrite_i,
  input  debugPkg::sprIndexT readAddr_i,
  output debugPkg::wordT     readData_o,
  output logic               debugIrq_o,
  output logic               stall_o
);

  debugPkg::reasonT dsrReg;
  debugPkg::reasonT drrReg;
  logic             stallReg;
  logic             irqReg;
  logic             takeException;
  logic             dsrWe;
  logic             drrWe;

  assign takeException = stage2_i.valid && stage2_i.exceptionTaken;
  assign dsrWe = sprWrite_i.strobe && sprWrite_i.index == debugPkg::DsrIndex;
  assign drrWe = sprWrite_i.strobe && sprWrite_i.index == debugPkg::DrrIndex;

  always_ff @(posedge clock)
  begin
    if (rst_i)
    begin
      dsrReg   <= '0;
      drrReg   <= '0;
      stallReg <= 1'b0;
      irqReg   <= 1'b0;
    end
    else
    begin
      irqReg <= stage2_i.valid && stage2_i.anyHit;
      if (dsrWe)
        dsrReg <= sprWrite_i.data.raw[13:0];
      if (takeException)
      begin
        drrReg   <= stage2_i.exceptionReason;                          // Last reason taken
        stallReg <= stallReg || (stage2_i.exceptionReason & dsrReg) != '0;
      end
      else if (drrWe)
      begin
        drrReg   <= sprWrite_i.data.raw[13:0];
        stallReg <= 1'b0;                                              // Host releases the core
      end
    end
  end

  always_comb
  begin
    case (readAddr_i)
      debugPkg::DsrIndex : readData_o = debugPkg::wordT'(dsrReg);
      debugPkg::DrrIndex : readData_o = debugPkg::wordT'(drrReg);
      default            : readData_o = '0;
    endcase
  end

  assign debugIrq_o = irqReg;
  assign stall_o    = stallReg;

endmodule

//--- debugUnit.sv
// Debug unit top; host SPR port plus a three-stage event pipeline
// debugIrq_o and stall follow an event by three cycles; nrOfBreakpoints from 0 to 8
`timescale 1ns/10ps

module debugUnit #(parameter int nrOfBreakpoints = 4)
(
  input  logic                clock,
  input  logic                rst_i,
  input  debugPkg::coreEventT coreEvent_i,
  input  logic                hostReq_i,
  input  logic                hostWe_i,
  input  debugPkg::sprIndexT  hostAddr_i,
  input  debugPkg::wordT      hostWData_i,
  output logic                hostAck_o,
  output debugPkg::wordT      hostRData_o,
  output logic [3:0]          loadStoreStatus_o,
  output logic                debugIrq_o,
  output logic                stall_o
);

  debugPkg::sprWriteT sprWrite;
  debugPkg::sprIndexT readAddr;
  debugPkg::wordT     bpRead;
  debugPkg::wordT     stopRead;
  debugPkg::stage1T   stage1;
  debugPkg::stage2T   stage2;

  sprAccessPort i_sprAccessPort (.clock(clock), .rst_i(rst_i), .hostReq_i(hostReq_i),
                                 .hostWe_i(hostWe_i), .hostAddr_i(hostAddr_i),
                                 .hostWData_i(hostWData_i), .bpRead_i(bpRead),
                                 .stopRead_i(stopRead), .hostAck_o(hostAck_o),
                                 .hostRData_o(hostRData_o), .sprWrite_o(sprWrite),
                                 .readAddr_o(readAddr));

  eventCapture i_eventCapture (.clock(clock), .rst_i(rst_i), .coreEvent_i(coreEvent_i),
                               .stage1_o(stage1), .loadStoreStatus_o(loadStoreStatus_o));

  breakpointMatch #(.nrOfBreakpoints(nrOfBreakpoints))
    i_breakpointMatch (.clock(clock), .rst_i(rst_i), .stage1_i(stage1),
                       .sprWrite_i(sprWrite), .readAddr_i(readAddr),
                       .stage2_o(stage2), .readData_o(bpRead));

  stopControl i_stopControl (.clock(clock), .rst_i(rst_i), .stage2_i(stage2),
                             .sprWrite_i(sprWrite), .readAddr_i(readAddr),
                             .readData_o(stopRead), .debugIrq_o(debugIrq_o),
                             .stall_o(stall_o));

endmodule

//--- debugUnit_sva.sv
// Handshake and reset checks, bound into every sprAccessPort
`timescale 1ns/10ps

module debugUnit_sva
(
  input logic               clock,
  input logic               rst_i,
  input logic               hostReq_i,
  input logic               hostAck_o,
  input debugPkg::wordT     hostRData_o,
  input debugPkg::sprWriteT sprWrite_o
);

  int failCount = 0;

  ackRelease : assert property (@(posedge clock) disable iff (rst_i)
    $fell(hostAck_o) |-> !$past(hostReq_i))
    else
    begin
      failCount++;
      $error("ack fell while req was still high");
    end

  strobeOnce : assert property (@(posedge clock) disable iff (rst_i)
    sprWrite_o.strobe |=> !sprWrite_o.strobe)
    else
    begin
      failCount++;
      $error("write strobe longer than one cycle");
    end

  resetQuiet : assert property (@(posedge clock)
    rst_i |=> (!hostAck_o && hostRData_o == '0))
    else
    begin
      failCount++;
      $error("port outputs not low after reset");
    end

endmodule

bind sprAccessPort debugUnit_sva i_debugUnit_sva
(
  .clock(clock), .rst_i(rst_i), .hostReq_i(hostReq_i), .hostAck_o(hostAck_o),
  .hostRData_o(hostRData_o), .sprWrite_o(sprWrite_o)
);

//--- debugUnit_tb.sv
// Testbench for debugUnit with four breakpoints; steps run in table order
// Host accesses start only after earlier events have drained from the pipeline
`timescale 1ns/10ps

module debugUnit_tb;

  typedef enum logic [1:0] {
    StepWrite,
    StepRead,
    StepEvent
  } stepKindE;

  typedef struct packed {
    stepKindE            kind;
    debugPkg::sprIndexT  addr;
    debugPkg::wordT      data;                 // Write data or expected read data
    debugPkg::coreEventT ev;
    logic [3:0]          status;
    logic                irq;
    logic                stall;
  } stepT;

  typedef struct packed {
    logic       valid;
    logic [7:0] step;
    logic [3:0] status;
    logic       irq;
    logic       stall;
  } expectT;

  localparam int AckTimeout = 16;

  logic                clock;
  logic                rst;
  logic                hostReq;
  logic                hostWe;
  debugPkg::sprIndexT  hostAddr;
  debugPkg::wordT      hostWData;
  debugPkg::coreEventT coreEvent;
  logic                hostAck;
  debugPkg::wordT      hostRData;
  logic [3:0]          loadStoreStatus;
  logic                debugIrq;
  logic                stall;

  stepT   steps[$];
  expectT pipe [4];                            // Index is the age of an event in cycles
  int     stepErrors [256];
  int     errorCount;
  int     passedSteps;
  int     failedSteps;
  bit     timedOut;

  debugUnit #(.nrOfBreakpoints(4)) i_debugUnit
  (
    .clock(clock), .rst_i(rst), .coreEvent_i(coreEvent),
    .hostReq_i(hostReq), .hostWe_i(hostWe), .hostAddr_i(hostAddr),
    .hostWData_i(hostWData), .hostAck_o(hostAck), .hostRData_o(hostRData),
    .loadStoreStatus_o(loadStoreStatus), .debugIrq_o(debugIrq), .stall_o(stall)
  );

  initial
  begin
    clock = 1'b0;
    forever
      #10 clock = ~clock;
  end

  function automatic void pushWrite(input debugPkg::sprIndexT addr, input debugPkg::wordT data);
    stepT s;
    s = '0;
    s.kind = StepWrite;
    s.addr = addr;
    s.data = data;
    steps.push_back(s);
  endfunction

  function automatic void queueRead(input debugPkg::sprIndexT addr, input debugPkg::wordT exp);
    stepT s;
    s = '0;
    s.kind = StepRead;
    s.addr = addr;
    s.data = exp;
    steps.push_back(s);
  endfunction

  // Fields that no access kind qualifies get random filler
  function automatic void appendEvent(input debugPkg::wordT fetch, input debugPkg::wordT mem,
                                      input debugPkg::loadKindE lk, input debugPkg::storeKindE sk,
                                      input debugPkg::wordT data, input debugPkg::reasonT reason,
                                      input logic [3:0] status, input logic irq, input logic stl);
    stepT s;
    s = '0;
    s.kind                 = StepEvent;
    s.ev.valid             = 1'b1;
    s.ev.fetchAddr         = fetch;
    s.ev.memAddr           = (lk == debugPkg::LoadNone && sk == debugPkg::StoreNone) ?
                             $urandom : mem;
    s.ev.loadKind          = lk;
    s.ev.storeKind         = sk;
    s.ev.loadData          = (lk == debugPkg::LoadNone) ? $urandom : data;
    s.ev.storeData         = (sk == debugPkg::StoreNone) ? $urandom : data;
    s.ev.exceptionTaken    = reason != '0;
    s.ev.exceptionReason   = reason;
    s.status               = status;
    s.irq                  = irq;
    s.stall                = stl;
    steps.push_back(s);
  endfunction

  task automatic noteMismatch(input int step);
    errorCount++;
    if (step >= 0)
      stepErrors[step]++;
  endtask

  task automatic compareReadData(input debugPkg::wordT got, input debugPkg::wordT exp,
                                 input int step);
    if (got !== exp)
    begin
      $display("error at %0d ns: step %0d read data %h, expected %h", $time, step, got, exp);
      noteMismatch(step);
    end
  endtask

  task automatic verifyStatus(input logic [3:0] got, input logic [3:0] exp, input int step);
    if (got !== exp)
    begin
      $display("error at %0d ns: step %0d load/store status %h, expected %h",
               $time, step, got, exp);
      noteMismatch(step);
    end
  endtask

  task automatic expectBit(input string what, input logic got, input logic exp, input int step);
    if (got !== exp)
    begin
      $display("error at %0d ns: step %0d %s is %b, expected %b", $time, step, what, got, exp);
      noteMismatch(step);
    end
  endtask

  task automatic printStepResult(input int step, input string kind);
    if (stepErrors[step] == 0)
    begin
      passedSteps++;
      $display("step %0d %s ok", step, kind);
    end
    else
    begin
      failedSteps++;
      $display("step %0d %s has %0d mismatches", step, kind, stepErrors[step]);
    end
  endtask

  // One falling edge; status is due one cycle after an event, irq and stall three
  task automatic nextFall();
    int statusStep;
    int lateStep;
    @(negedge clock);
    for (int a = 3; a > 0; a--)
      pipe[a] = pipe[a-1];
    pipe[0]    = '0;
    statusStep = pipe[1].valid ? int'(pipe[1].step) : -1;
    lateStep   = pipe[3].valid ? int'(pipe[3].step) : -1;
    verifyStatus(loadStoreStatus, pipe[1].valid ? pipe[1].status : 4'h0, statusStep);
    expectBit("debugIrq_o", debugIrq, pipe[3].valid && pipe[3].irq, lateStep);
    if (pipe[3].valid)
    begin
      expectBit("stall_o", stall, pipe[3].stall, lateStep);
      printStepResult(lateStep, "event");
    end
    coreEvent = '0;                            // Idle unless a new event is driven
  endtask

  task automatic drainPipeline();
    int guard;
    guard = 0;
    while ((pipe[0].valid || pipe[1].valid || pipe[2].valid) && guard < 8)
    begin
      nextFall();
      guard++;
    end
  endtask

  task automatic hostAccess(input logic we, input debugPkg::sprIndexT addr,
                            input debugPkg::wordT wdata, output debugPkg::wordT rdata);
    int waitCount;
    rdata = '0;
    nextFall();
    hostReq   = 1'b1;
    hostWe    = we;
    hostAddr  = addr;
    hostWData = wdata;
    waitCount = 0;
    while (!hostAck && waitCount < AckTimeout)
    begin
      nextFall();
      waitCount++;
    end
    rdata   = hostRData;                       // Valid while ack is high
    hostReq = 1'b0;
    hostWe  = 1'b0;
    if (!hostAck)
    begin
      timedOut = 1'b1;
      $display("timeout: no ack from the DUT for SPR %h", addr);
    end
    else
    begin
      waitCount = 0;
      while (hostAck && waitCount < AckTimeout)
      begin
        nextFall();
        waitCount++;
      end
      if (hostAck)
      begin
        timedOut = 1'b1;
        $display("timeout: the DUT kept ack high after req dropped, SPR %h", addr);
      end
    end
  endtask

  initial
  begin
    stepT           s;
    debugPkg::wordT rdata;
    rst       = 1'b1;
    hostReq   = 1'b0;
    hostWe    = 1'b0;
    hostAddr  = '0;
    hostWData = '0;
    coreEvent = '0;
    for (int a = 0; a < 4; a++)
      pipe[a] = '0;
    void'($urandom(8));

    pushWrite(16'h3000, 32'h1234_5678);
    pushWrite(16'h3008, 32'hFFFF_FFFF);        // Only bits 7:1 stick
    pushWrite(16'h3009, 32'h1234_5633);
    pushWrite(16'h3003, 32'hCAFE_F00D);
    pushWrite(16'h3004, 32'h1111_1111);        // Not implemented
    pushWrite(16'h300C, 32'hFFFF_FFFF);
    pushWrite(16'h3014, 32'hFFFF_FFFF);
    pushWrite(16'h3015, 32'hFFFF_FFFF);
    queueRead(16'h3000, 32'h1234_5678);
    queueRead(16'h3008, 32'h0000_00FE);
    queueRead(16'h3009, 32'h0000_0032);
    queueRead(16'h3003, 32'hCAFE_F00D);
    queueRead(16'h3004, 32'h0);
    queueRead(16'h300C, 32'h0);
    queueRead(16'h3010, 32'h0);                // Unknown index
    queueRead(16'h3014, 32'h3FFF);
    queueRead(16'h3015, 32'h3FFF);

    pushWrite(16'h3000, 32'h1000);
    pushWrite(16'h3008, 32'h22);               // Fetch equal
    pushWrite(16'h3001, 32'h10);
    pushWrite(16'h3009, 32'h24);               // Fetch below, unsigned
    appendEvent(32'h1000, 0, debugPkg::LoadNone, debugPkg::StoreNone, 0, 0, 4'h0, 1, 0);
    appendEvent(32'h1004, 0, debugPkg::LoadNone, debugPkg::StoreNone, 0, 0, 4'h0, 0, 0);
    appendEvent(32'hFFFF_FFF0, 0, debugPkg::LoadNone, debugPkg::StoreNone, 0, 0, 4'h0, 0, 0);
    pushWrite(16'h3009, 32'h34);               // Fetch below, signed
    appendEvent(32'hFFFF_FFF0, 0, debugPkg::LoadNone, debugPkg::StoreNone, 0, 0, 4'h0, 1, 0);
    pushWrite(16'h3008, 32'h0);
    pushWrite(16'h3009, 32'h0);

    pushWrite(16'h3002, 32'h2000);
    pushWrite(16'h300A, 32'h42);               // Load address equal
    appendEvent(32'h100, 32'h2000, debugPkg::LoadNone, debugPkg::StoreWord, 32'h55, 0,
                4'hE, 0, 0);
    appendEvent(32'h104, 32'h2000, debugPkg::LoadWordZero, debugPkg::StoreNone, 32'h66, 0,
                4'h6, 1, 0);
    pushWrite(16'h300A, 32'h0);
    pushWrite(16'h300B, 32'hCC);               // Store data not equal
    appendEvent(32'h108, 32'h3000, debugPkg::LoadByteSign, debugPkg::StoreNone, 32'h1, 0,
                4'h3, 0, 0);
    appendEvent(32'h10C, 32'h3004, debugPkg::LoadNone, debugPkg::StoreByte, 32'h5, 0,
                4'hA, 1, 0);
    appendEvent(32'h110, 32'h3008, debugPkg::LoadNone, debugPkg::StoreHalf, 32'hCAFE_F00D, 0,
                4'hC, 0, 0);
    pushWrite(16'h300B, 32'h0);

    appendEvent(32'h200, 32'h4000, debugPkg::LoadByteZero, debugPkg::StoreNone, 32'h7F, 0,
                4'h2, 0, 0);
    appendEvent(32'h204, 32'h4002, debugPkg::LoadHalfZero, debugPkg::StoreNone, 32'h7F, 0,
                4'h4, 0, 0);
    appendEvent(32'h208, 32'h4004, debugPkg::LoadHalfSign, debugPkg::StoreNone, 32'h7F, 0,
                4'h5, 0, 0);
    appendEvent(32'h20C, 32'h4008, debugPkg::LoadWordSign, debugPkg::StoreNone, 32'h7F, 0,
                4'h7, 0, 0);
    appendEvent(32'h210, 0, debugPkg::LoadNone, debugPkg::StoreNone, 0, 0, 4'h0, 0, 0);
    appendEvent(32'h214, 32'h400C, debugPkg::LoadWordZero, debugPkg::StoreWord, 32'h7F, 0,
                4'h0, 0, 0);             // Load and store together

    pushWrite(16'h3008, 32'h22);
    appendEvent(32'h1000, 0, debugPkg::LoadNone, debugPkg::StoreNone, 0, 0, 4'h0, 1, 0);
    appendEvent(32'h2000, 0, debugPkg::LoadNone, debugPkg::StoreNone, 0, 0, 4'h0, 0, 0);
    appendEvent(32'h1000, 0, debugPkg::LoadNone, debugPkg::StoreNone, 0, 0, 4'h0, 1, 0);
    appendEvent(32'h1000, 0, debugPkg::LoadNone, debugPkg::StoreNone, 0, 0, 4'h0, 1, 0);
    pushWrite(16'h3008, 32'h0);

    pushWrite(16'h3014, 32'h0010);
    pushWrite(16'h3015, 32'h0);
    appendEvent(32'h300, 0, debugPkg::LoadNone, debugPkg::StoreNone, 0, 14'h0100, 4'h0, 0, 0);
    queueRead(16'h3015, 32'h0100);
    appendEvent(32'h304, 0, debugPkg::LoadNone, debugPkg::StoreNone, 0, 14'h0030, 4'h0, 0, 1);
    queueRead(16'h3015, 32'h0030);
    appendEvent(32'h308, 0, debugPkg::LoadNone, debugPkg::StoreNone, 0, 0, 4'h0, 0, 1);
    pushWrite(16'h3015, 32'h0);                // Releases the stall
    appendEvent(32'h30C, 0, debugPkg::LoadNone, debugPkg::StoreNone, 0, 0, 4'h0, 0, 0);
    queueRead(16'h3015, 32'h0);

    repeat (5) @(negedge clock);
    rst = 1'b0;

    for (int i = 0; i < steps.size() && !timedOut; i++)
    begin
      s = steps[i];
      case (s.kind)
        StepEvent :
        begin
          nextFall();
          coreEvent = s.ev;
          pipe[0]   = '{valid: 1'b1, step: 8'(i), status: s.status, irq: s.irq, stall: s.stall};
        end
        default :
        begin
          drainPipeline();
          hostAccess(s.kind == StepWrite, s.addr, s.data, rdata);
          if (s.kind == StepRead && !timedOut)
            compareReadData(rdata, s.data, i);
          if (!timedOut)
            printStepResult(i, (s.kind == StepWrite) ? "write" : "read");
        end
      endcase
    end
    drainPipeline();

    $display("steps passed %0d failed %0d, mismatches %0d, assertion failures %0d",
             passedSteps, failedSteps, errorCount,
             i_debugUnit.i_sprAccessPort.i_debugUnit_sva.failCount);
    if (errorCount == 0 && failedSteps == 0 && !timedOut &&
        i_debugUnit.i_sprAccessPort.i_debugUnit_sva.failCount == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- verilog.f
debugPkg.sv
sprAccessPort.sv
eventCapture.sv
breakpointMatch.sv
stopControl.sv
debugUnit.sv
debugUnit_sva.sv
debugUnit_tb.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator; the exit status follows the result in sim.log
rm -f sim.log
verilator --binary --assert --top-module debugUnit_tb -f verilog.f -o debugUnitSim \
  && ./obj_dir/debugUnitSim > sim.log 2>&1 \
  && grep -q "^>>> PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
